// ==== source/tx_mux_pkg.sv ====
`default_nettype none

// sizes and request encoding shared by every block of the transmit mux
package tx_mux_pkg;

    // request sources and queue sizing
    localparam int N_PORTS        = 4;
    localparam int PORT_W         = 2;
    localparam int FIFO_DEPTH     = 8;
    localparam int CNT_W          = 4;

    // two requests can still land after the flag rises, so it goes up with two slots left
    localparam int ALMFULL_THRESH = 6;

    // request fields
    localparam int ADDR_W = 24;
    localparam int TAG_W  = 8;
    localparam int DATA_W = 8;
    localparam int REQ_W  = 32;

    // kind bit kept beside each queue word
    localparam logic KIND_RD = 1'b0;
    localparam logic KIND_WR = 1'b1;

    // one queue word, seen as a read or as a write depending on the kind bit
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]  tag;
            logic [ADDR_W-1:0] addr;
        } rd;
        struct packed {
            logic [DATA_W-1:0] data;
            logic [ADDR_W-1:0] addr;
        } wr;
    } req_word_t;

endpackage

`default_nettype wire

// ==== source/req_enqueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_enqueue
    import tx_mux_pkg::*;
(
    input  logic              clk,
    input  logic              reset_q,

    // source strobe and its fields
    input  logic              src_valid,
    input  logic              src_is_write,
    input  logic [ADDR_W-1:0] src_addr,
    input  logic [TAG_W-1:0]  src_tag,
    input  logic [DATA_W-1:0] src_data,

    // queue write side
    input  logic              full,
    output logic              push,
    output logic              push_kind,
    output req_word_t         push_word
);

    req_word_t packed_word;
    logic      valid_q;
    logic      kind_q;
    req_word_t word_q;

    // the kind decides whether the tag or the data fills the upper byte
    always_comb
    begin
        if (src_is_write)
        begin
            packed_word.wr.data = src_data;
            packed_word.wr.addr = src_addr;
        end
        else
        begin
            packed_word.rd.tag  = src_tag;
            packed_word.rd.addr = src_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= src_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (src_valid)
        begin
            kind_q <= src_is_write ? KIND_WR : KIND_RD;
            word_q <= packed_word;
        end
    end

    // a request that meets a full queue is lost here
    assign push      = valid_q && !full;
    assign push_kind = kind_q;
    assign push_word = word_q;

endmodule

`default_nettype wire

// ==== source/req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo
    import tx_mux_pkg::*;
(
    input  logic      clk,
    input  logic      reset_q,

    // write side, push is trusted
    input  logic      push,
    input  logic      push_kind,
    input  req_word_t push_word,

    // read side
    input  logic      pop,
    output req_word_t head_word,
    output logic      head_kind,
    output logic      not_empty,
    output logic      full,
    output logic      almost_full
);

    logic [REQ_W-1:0]              word_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]         kind_mem;
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [CNT_W-1:0]              count;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            word_mem[wr_ptr] <= push_word;
            kind_mem[wr_ptr] <= push_kind;
        end
    end

    // pointers wrap by themselves as the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            count <= '0;
        end
        else
        begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head comes straight off the array, valid right after the push edge
    assign head_word   = word_mem[rd_ptr];
    assign head_kind   = kind_mem[rd_ptr];

    assign not_empty   = (count != '0);
    assign full        = (count == CNT_W'(FIFO_DEPTH));
    assign almost_full = (count >= CNT_W'(ALMFULL_THRESH));

endmodule

`default_nettype wire

// ==== source/rr_dequeue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_dequeue
    import tx_mux_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_q,

    // downstream back-pressure
    input  logic                    rd_almfull,
    input  logic                    wr_almfull,

    // per-port queue heads
    input  req_word_t [N_PORTS-1:0] head_word,
    input  logic [N_PORTS-1:0]      head_kind,
    input  logic [N_PORTS-1:0]      not_empty,
    output logic [N_PORTS-1:0]      pop,

    // read channel
    output logic                    rd_valid,
    output logic [ADDR_W-1:0]       rd_addr,
    output logic [TAG_W-1:0]        rd_tag,
    output logic [PORT_W-1:0]       rd_port,

    // write channel
    output logic                    wr_valid,
    output logic [ADDR_W-1:0]       wr_addr,
    output logic [DATA_W-1:0]       wr_data,
    output logic [PORT_W-1:0]       wr_port
);

    logic [PORT_W-1:0]  slot_q;
    logic               rd_almfull_q;
    logic               wr_almfull_q;
    logic               slot_blocked;
    logic [N_PORTS-1:0] pop_next;
    logic [N_PORTS-1:0] pop_q;
    logic [PORT_W-1:0]  pop_port_q;
    logic               pop_any;
    req_word_t          pop_word;
    logic               pop_kind;

    // only the head's own channel can hold a port off
    always_comb
    begin
        slot_blocked = (head_kind[slot_q] == KIND_WR) ? wr_almfull_q : rd_almfull_q;
        pop_next     = '0;
        if (not_empty[slot_q] && !slot_blocked)
        begin
            pop_next[slot_q] = 1'b1;
        end
    end

    // the slot moves every cycle, so a port is looked at once in four cycles
    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            slot_q       <= '0;
            rd_almfull_q <= 1'b0;
            wr_almfull_q <= 1'b0;
            pop_q        <= '0;
        end
        else
        begin
            slot_q       <= slot_q + 1'b1;
            rd_almfull_q <= rd_almfull;
            wr_almfull_q <= wr_almfull;
            pop_q        <= pop_next;
        end
    end

    always_ff @(posedge clk)
    begin
        pop_port_q <= slot_q;
    end

    assign pop_any  = |pop_q;
    assign pop_word = head_word[pop_port_q];
    assign pop_kind = head_kind[pop_port_q];

    // head is taken in the pop cycle, output strobe follows one cycle later
    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= pop_any && (pop_kind == KIND_RD);
            wr_valid <= pop_any && (pop_kind == KIND_WR);
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop_any)
        begin
            if (pop_kind == KIND_WR)
            begin
                wr_addr <= pop_word.wr.addr;
                wr_data <= pop_word.wr.data;
                wr_port <= pop_port_q;
            end
            else
            begin
                rd_addr <= pop_word.rd.addr;
                rd_tag  <= pop_word.rd.tag;
                rd_port <= pop_port_q;
            end
        end
    end

    assign pop = pop_q;

endmodule

`default_nettype wire

// ==== source/tx_mux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_mux_top
    import tx_mux_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset_q,

    // request sources, one slice per port
    input  logic [N_PORTS-1:0]             src_valid,
    input  logic [N_PORTS-1:0]             src_is_write,
    input  logic [N_PORTS-1:0][ADDR_W-1:0] src_addr,
    input  logic [N_PORTS-1:0][TAG_W-1:0]  src_tag,
    input  logic [N_PORTS-1:0][DATA_W-1:0] src_data,
    output logic [N_PORTS-1:0]             src_almfull,

    // downstream almost-full
    input  logic                           rd_almfull,
    input  logic                           wr_almfull,

    // merged read channel
    output logic                           rd_valid,
    output logic [ADDR_W-1:0]              rd_addr,
    output logic [TAG_W-1:0]               rd_tag,
    output logic [PORT_W-1:0]              rd_port,

    // merged write channel
    output logic                           wr_valid,
    output logic [ADDR_W-1:0]              wr_addr,
    output logic [DATA_W-1:0]              wr_data,
    output logic [PORT_W-1:0]              wr_port
);

    logic [N_PORTS-1:0]      push;
    logic [N_PORTS-1:0]      push_kind;
    req_word_t [N_PORTS-1:0] push_word;
    logic [N_PORTS-1:0]      full;
    req_word_t [N_PORTS-1:0] head_word;
    logic [N_PORTS-1:0]      head_kind;
    logic [N_PORTS-1:0]      not_empty;
    logic [N_PORTS-1:0]      pop;

    generate
        for (genvar i = 0; i < N_PORTS; i++)
        begin : g_port
            req_enqueue u_enq (
                .clk          (clk),
                .reset_q      (reset_q),
                .src_valid    (src_valid[i]),
                .src_is_write (src_is_write[i]),
                .src_addr     (src_addr[i]),
                .src_tag      (src_tag[i]),
                .src_data     (src_data[i]),
                .full         (full[i]),
                .push         (push[i]),
                .push_kind    (push_kind[i]),
                .push_word    (push_word[i])
            );

            // almost-full of each queue goes straight back to its source
            req_fifo u_fifo (
                .clk          (clk),
                .reset_q      (reset_q),
                .push         (push[i]),
                .push_kind    (push_kind[i]),
                .push_word    (push_word[i]),
                .pop          (pop[i]),
                .head_word    (head_word[i]),
                .head_kind    (head_kind[i]),
                .not_empty    (not_empty[i]),
                .full         (full[i]),
                .almost_full  (src_almfull[i])
            );
        end
    endgenerate

    rr_dequeue u_deq (
        .clk        (clk),
        .reset_q    (reset_q),
        .rd_almfull (rd_almfull),
        .wr_almfull (wr_almfull),
        .head_word  (head_word),
        .head_kind  (head_kind),
        .not_empty  (not_empty),
        .pop        (pop),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_tag     (rd_tag),
        .rd_port    (rd_port),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_port    (wr_port)
    );

endmodule

`default_nettype wire

// ==== verif/tx_mux_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_mux_chk
    import tx_mux_pkg::*;
(
    input logic               clk,
    input logic               reset_q,
    input logic [N_PORTS-1:0] pop,
    input logic [N_PORTS-1:0] not_empty,
    input logic               rd_valid,
    input logic               wr_valid
);

    // the arbiter takes from at most one queue per cycle
    a_pop_onehot: assert property (@(posedge clk) disable iff (reset_q)
        $onehot0(pop))
        else $error("more than one queue popped in the same cycle");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (reset_q)
        (pop & ~not_empty) == '0)
        else $error("pop issued to an empty queue");

    // a popped word leaves on one channel only
    a_one_channel: assert property (@(posedge clk) disable iff (reset_q)
        !(rd_valid && wr_valid))
        else $error("rd_valid and wr_valid high in the same cycle");

endmodule

bind tx_mux_top tx_mux_chk u_chk (
    .clk       (clk),
    .reset_q   (reset_q),
    .pop       (pop),
    .not_empty (not_empty),
    .rd_valid  (rd_valid),
    .wr_valid  (wr_valid)
);

`default_nettype wire

// ==== verif/tx_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_mux_tb
    import tx_mux_pkg::*;
();

    localparam string CASE_FILE   = "verif/tx_mux_cases.txt";
    localparam int    DRAIN_LIMIT = 160;

    logic                           clk;
    logic                           reset_q;
    logic [N_PORTS-1:0]             src_valid;
    logic [N_PORTS-1:0]             src_is_write;
    logic [N_PORTS-1:0][ADDR_W-1:0] src_addr;
    logic [N_PORTS-1:0][TAG_W-1:0]  src_tag;
    logic [N_PORTS-1:0][DATA_W-1:0] src_data;
    logic [N_PORTS-1:0]             src_almfull;
    logic                           rd_almfull;
    logic                           wr_almfull;
    logic                           rd_valid;
    logic [ADDR_W-1:0]              rd_addr;
    logic [TAG_W-1:0]               rd_tag;
    logic [PORT_W-1:0]              rd_port;
    logic                           wr_valid;
    logic [ADDR_W-1:0]              wr_addr;
    logic [DATA_W-1:0]              wr_data;
    logic [PORT_W-1:0]              wr_port;

    // expected words per port and channel, in issue order
    req_word_t   exp_rd [N_PORTS][$];
    req_word_t   exp_wr [N_PORTS][$];
    string       cur_test      = "reset";
    int          cur_mode      = 0;
    logic [31:0] rng_state     = 32'h1fc4634c;
    int          rd_hold       = 0;
    int          wr_hold       = 0;
    int          cycle_cnt     = 0;
    int          timeout_limit = 200;

    tx_mux_top DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit queues_empty(input bit writes_only);
        for (int p = 0; p < N_PORTS; p++)
        begin
            if (exp_wr[PORT_W'(p)].size() != 0
                || (!writes_only && exp_rd[PORT_W'(p)].size() != 0))
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rd(input string name, input logic [PORT_W-1:0] port,
                            input req_word_t exp, input req_word_t act);
        if (act.rd.addr !== exp.rd.addr || act.rd.tag !== exp.rd.tag)
        begin
            $display("FAIL %s read port %0d: expected addr %h tag %h, actual addr %h tag %h",
                     name, port, exp.rd.addr, exp.rd.tag, act.rd.addr, act.rd.tag);
            stop_run();
        end
    endtask

    task automatic check_wr(input string name, input logic [PORT_W-1:0] port,
                            input req_word_t exp, input req_word_t act);
        if (act.wr.addr !== exp.wr.addr || act.wr.data !== exp.wr.data)
        begin
            $display("FAIL %s write port %0d: expected addr %h data %h, actual addr %h data %h",
                     name, port, exp.wr.addr, exp.wr.data, act.wr.addr, act.wr.data);
            stop_run();
        end
    endtask

    task automatic check_flags(input string name, input logic [N_PORTS-1:0] exp,
                               input logic [N_PORTS-1:0] act);
        if (act !== exp)
        begin
            $display("FAIL %s src_almfull: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // mode 1 holds reads, mode 2 holds writes, mode 3 toggles both at random
    task automatic apply_almfull();
        case (cur_mode)
            1:
            begin
                rd_almfull = 1'b1;
                wr_almfull = 1'b0;
            end
            2:
            begin
                rd_almfull = 1'b0;
                wr_almfull = 1'b1;
            end
            3:
            begin
                rng_state  = lcg_next(rng_state);
                rd_almfull = rng_state[31];
                wr_almfull = rng_state[29];
            end
            default:
            begin
                rd_almfull = 1'b0;
                wr_almfull = 1'b0;
            end
        endcase
    endtask

    task automatic next_cycle();
        @(negedge clk);
        src_valid = '0;
        apply_almfull();
    endtask

    task automatic issue_request(input logic [PORT_W-1:0] port, input bit is_write,
                                 input logic [ADDR_W-1:0] addr, input logic [7:0] val);
        req_word_t exp;
        src_valid[port]    = 1'b1;
        src_is_write[port] = is_write;
        src_addr[port]     = addr;
        src_tag[port]      = val;
        src_data[port]     = val;
        if (is_write)
        begin
            exp.wr.data = val;
            exp.wr.addr = addr;
            exp_wr[port].push_back(exp);
        end
        else
        begin
            exp.rd.tag  = val;
            exp.rd.addr = addr;
            exp_rd[port].push_back(exp);
        end
    endtask

    task automatic finish_test(input bit flag_chk, input logic [N_PORTS-1:0] flag_exp);
        int waited;
        waited = 0;
        if (flag_chk)
        begin
            check_flags(cur_test, flag_exp, src_almfull);
        end
        if (cur_mode == 1 && !queues_empty(1'b1))
        begin
            $display("writes did not flow while reads were held in test %s", cur_test);
            stop_run();
        end
        cur_mode = 0;
        next_cycle();
        while (!queues_empty(1'b0) && waited < DRAIN_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!queues_empty(1'b0))
        begin
            $display("test %s ended with expected requests that never came out", cur_test);
            stop_run();
        end
        next_cycle();
        check_flags(cur_test, '0, src_almfull);
    endtask

    // consecutive cycles each downstream flag has been high
    always @(posedge clk)
    begin
        rd_hold   <= rd_almfull ? rd_hold + 1 : 0;
        wr_hold   <= wr_almfull ? wr_hold + 1 : 0;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit)
        begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            stop_run();
        end
    end

    always @(negedge clk)
    begin
        req_word_t exp;
        req_word_t act;
        if (!reset_q && rd_valid)
        begin
            if (rd_hold >= 3 || exp_rd[rd_port].size() == 0)
            begin
                $display("unexpected read from port %0d in test %s", rd_port, cur_test);
                stop_run();
            end
            exp         = exp_rd[rd_port].pop_front();
            act.rd.addr = rd_addr;
            act.rd.tag  = rd_tag;
            check_rd(cur_test, rd_port, exp, act);
        end
        if (!reset_q && wr_valid)
        begin
            if (wr_hold >= 3 || exp_wr[wr_port].size() == 0)
            begin
                $display("unexpected write from port %0d in test %s", wr_port, cur_test);
                stop_run();
            end
            exp         = exp_wr[wr_port].pop_front();
            act.wr.addr = wr_addr;
            act.wr.data = wr_data;
            check_wr(cur_test, wr_port, exp, act);
        end
    end

    initial
    begin
        int                 fd;
        int                 code;
        int                 port;
        int                 gap;
        int                 mode;
        int                 flag_chk;
        string              line;
        string              kw;
        string              kind;
        logic [ADDR_W-1:0]  addr;
        logic [7:0]         val;
        logic [N_PORTS-1:0] flag_exp;

        clk          = 1'b0;
        reset_q      = 1'b1;
        src_valid    = '0;
        src_is_write = '0;
        src_addr     = '0;
        src_tag      = '0;
        src_data     = '0;
        rd_almfull   = 1'b0;
        wr_almfull   = 1'b0;
        repeat (5) @(negedge clk);
        reset_q = 1'b0;
        repeat (4) next_cycle();

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the case file %s", CASE_FILE);
            stop_run();
        end
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            timeout_limit = timeout_limit + 64;
            code = $sscanf(line, "%s", kw);
            if (kw == "req")
            begin
                code = $sscanf(line, "%s %s %d %s %h %h %d %d",
                               kw, cur_test, port, kind, addr, val, gap, mode);
                if (code != 8 || port >= N_PORTS)
                begin
                    $display("malformed request line in the case file: %s", line);
                    stop_run();
                end
                cur_mode = mode;
                apply_almfull();
                issue_request(PORT_W'(port), kind == "wr", addr, val);
                repeat (gap) next_cycle();
            end
            else if (kw == "end")
            begin
                code = $sscanf(line, "%s %s %d %h", kw, cur_test, flag_chk, flag_exp);
                finish_test(flag_chk != 0, flag_exp);
            end
            else
            begin
                $display("unknown line in the case file: %s", line);
                stop_run();
            end
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/tx_mux_pkg.sv
source/req_enqueue.sv
source/req_fifo.sv
source/rr_dequeue.sv
source/tx_mux_top.sv
verif/tx_mux_chk.sv
verif/tx_mux_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tx_mux_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tx_mux_cases.txt ====
# req <test> <port> <rd|wr> <addr hex> <tag or data hex> <gap cycles> <almfull 0 off 1 rd 2 wr 3 random>
# end <test> <check src_almfull 0|1> <expected src_almfull hex>
end reset 1 0
req single 1 rd 123456 a5 1 0
req single 1 wr 00beef 3c 1 0
req single 3 wr abcdef 77 1 0
req single 3 rd 000010 01 12 0
end single 1 0
req burst 0 rd 100000 10 0 0
req burst 1 wr 110000 11 0 0
req burst 2 rd 120000 12 0 0
req burst 3 wr 130000 13 1 0
req burst 0 wr 100001 20 0 0
req burst 1 rd 110001 21 0 0
req burst 2 wr 120001 22 0 0
req burst 3 rd 130001 23 1 0
req burst 0 rd 100002 30 0 0
req burst 1 wr 110002 31 0 0
req burst 2 rd 120002 32 0 0
req burst 3 wr 130002 33 4 0
end burst 0 0
req rdstall 0 rd 200000 40 0 1
req rdstall 2 wr 220000 42 1 1
req rdstall 1 rd 210000 41 0 1
req rdstall 3 wr 230000 43 1 1
req rdstall 0 rd 200001 44 0 1
req rdstall 2 wr 220001 45 24 1
end rdstall 0 0
req random 0 rd 300000 50 1 3
req random 1 wr 310000 51 0 3
req random 2 rd 320000 52 2 3
req random 3 wr 330000 53 1 3
req random 0 wr 300001 54 0 3
req random 2 wr 320001 55 3 3
req random 1 rd 310001 56 1 3
req random 3 rd 330001 57 2 3
req random 0 rd 300002 58 6 3
end random 0 0
req srcfull 2 wr 400000 60 1 2
req srcfull 2 wr 400001 61 1 2
req srcfull 2 wr 400002 62 1 2
req srcfull 2 wr 400003 63 1 2
req srcfull 2 wr 400004 64 1 2
req srcfull 2 wr 400005 65 4 2
end srcfull 1 4
